// ==== filelist.f ====
verilog/swu_pkg.sv
verilog/swu_line_buffer.sv
verilog/swu_write_ctrl.sv
verilog/swu_window_fsm.sv
verilog/swu_read_addr.sv
verilog/swu_out_stage.sv
verilog/swu_top.sv
dv/swu_tb.sv

// ==== dv/swu_tb.sv ====
module swu_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int FRAME_WORDS = swu_pkg::IFM_HEIGHT * swu_pkg::ROW_WORDS;
   localparam int WINDOWS     = swu_pkg::OFM_HEIGHT * swu_pkg::OFM_WIDTH;
   localparam int WIN_BEATS   = swu_pkg::KERNEL * swu_pkg::KERNEL * swu_pkg::EFF_CHANNELS;
   localparam int BEATS       = WINDOWS * WIN_BEATS;
   localparam int NUM_FRAMES  = 7;
   localparam int TIMEOUT     = 5000;

   logic           clk;
   logic           resetn;
   swu_pkg::word_t s_data_i;
   logic           s_valid_i;
   logic           s_ready_o;
   swu_pkg::beat_t m_beat_o;
   logic           m_valid_o;
   logic           m_ready_i;

   swu_pkg::word_t in_words [NUM_FRAMES*FRAME_WORDS];
   integer         seed = 32'he7ac_5dc5;
   int             errors;
   int             checks;
   int             beats_seen;
   int             in_accepted;
   int             exp_frame;
   int             exp_idx;
   int             wl_count;
   int             fl_count;
   logic           was_stalled;
   swu_pkg::beat_t held_beat;

   swu_top u_dut (
      .clk       (clk),
      .resetn    (resetn),
      .s_data_i  (s_data_i),
      .s_valid_i (s_valid_i),
      .s_ready_o (s_ready_o),
      .m_beat_o  (m_beat_o),
      .m_valid_o (m_valid_o),
      .m_ready_i (m_ready_i)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   ////////////////////
   // helpers

   // expected beat idx of frame f, windows in kh, kw, channel group order
   function automatic swu_pkg::beat_t ref_beat(input int f, input int idx);
      int             ch;
      int             kw;
      int             kh;
      int             col;
      int             orow;
      int             pos;
      swu_pkg::beat_t b;
      ch   = idx % swu_pkg::EFF_CHANNELS;
      kw   = (idx / swu_pkg::EFF_CHANNELS) % swu_pkg::KERNEL;
      kh   = (idx / (swu_pkg::EFF_CHANNELS * swu_pkg::KERNEL)) % swu_pkg::KERNEL;
      col  = (idx / WIN_BEATS) % swu_pkg::OFM_WIDTH;
      orow = idx / (WIN_BEATS * swu_pkg::OFM_WIDTH);
      pos  = (orow * swu_pkg::STRIDE + kh) * swu_pkg::ROW_WORDS +
             (col * swu_pkg::STRIDE + kw) * swu_pkg::EFF_CHANNELS + ch;
      b.data        = in_words[f*FRAME_WORDS + pos];
      b.window_last = (ch == swu_pkg::EFF_CHANNELS - 1) && (kw == swu_pkg::KERNEL - 1) &&
                      (kh == swu_pkg::KERNEL - 1);
      b.frame_last  = b.window_last && (col == swu_pkg::OFM_WIDTH - 1) &&
                      (orow == swu_pkg::OFM_HEIGHT - 1);
      return b;
   endfunction

   function automatic bit chance(input int pct);
      return (($random(seed) & 32'h7fff_ffff) % 100) < pct;
   endfunction

   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      checks++;
      if (exp !== act) begin
         $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic fail_timeout(input string what);
      $display("timeout at %0t: %s", $time, what);
      $display("Testbench failed");
      $finish;
   endtask

   task automatic apply_reset();
      resetn    = 1'b0;
      s_valid_i = 1'b0;
      repeat (4) @(posedge clk);
      #2;
      resetn = 1'b1;
   endtask

   task automatic start_frame(input int f);
      exp_frame = f;
      exp_idx   = 0;
   endtask

   // n words of frame f, valid held until taken, gaps only between words
   task automatic send_words(input int f, input int n, input int gap_pct);
      int start;
      int seen;
      int idle;
      bit held;
      start = in_accepted;
      idle  = 0;
      held  = 1'b0;
      while (in_accepted - start < n) begin
         if (!held) begin
            if (chance(gap_pct)) begin
               s_valid_i = 1'b0;
            end else begin
               s_valid_i = 1'b1;
               s_data_i  = in_words[f*FRAME_WORDS + in_accepted - start];
               held      = 1'b1;
            end
         end
         seen = in_accepted;
         @(posedge clk);
         #2;
         if (in_accepted != seen) begin
            held = 1'b0;
            idle = 0;
         end else begin
            idle++;
         end
         if (idle > TIMEOUT) begin
            fail_timeout("input stream stopped accepting words");
         end
      end
      s_valid_i = 1'b0;
   endtask

   task automatic run_outputs(input int target, input int stall_pct);
      int waited;
      waited = 0;
      while (beats_seen < target) begin
         @(posedge clk);
         #2;
         m_ready_i = !chance(stall_pct);
         waited++;
         if (waited > TIMEOUT) begin
            fail_timeout("output beats stopped arriving");
         end
      end
      m_ready_i = 1'b1;
   endtask

   task automatic report_test(input int num, input string name, input int err_start);
      $display("test %0d %s: done, %0d beats so far, %0d new errors",
               num, name, beats_seen, errors - err_start);
   endtask

   ////////////////////
   // monitor on both streams
   always @(posedge clk) begin
      swu_pkg::beat_t exp_b;
      if (!resetn) begin
         was_stalled = 1'b0;
      end else begin
         if (s_valid_i && s_ready_o) begin
            in_accepted++;
         end
         if (was_stalled) begin
            check_value("m_valid_o", 1'b1, m_valid_o);
            check_value("m_beat_o held", held_beat, m_beat_o);
         end
         if (m_valid_o && m_ready_i) begin
            exp_b = ref_beat(exp_frame, exp_idx);
            check_value("m_beat_o.data", exp_b.data, m_beat_o.data);
            check_value("m_beat_o.window_last", exp_b.window_last, m_beat_o.window_last);
            check_value("m_beat_o.frame_last", exp_b.frame_last, m_beat_o.frame_last);
            wl_count += m_beat_o.window_last;
            fl_count += m_beat_o.frame_last;
            beats_seen++;
            exp_idx++;
            if (exp_idx == BEATS) begin
               exp_idx = 0;
               exp_frame++;
            end
         end
         was_stalled = m_valid_o && !m_ready_i;
         held_beat   = m_beat_o;
      end
   end

   ////////////////////
   // test sequence
   initial begin
      int err_start;
      int acc_start;
      resetn    = 1'b0;
      s_data_i  = '0;
      s_valid_i = 1'b0;
      m_ready_i = 1'b0;
      for (int i = 0; i < NUM_FRAMES*FRAME_WORDS; i++) begin
         in_words[i] = $random(seed);
      end
      apply_reset();

      // single frame, no back-pressure
      err_start = errors;
      wl_count  = 0;
      fl_count  = 0;
      start_frame(0);
      m_ready_i = 1'b1;
      fork
         send_words(0, FRAME_WORDS, 0);
         run_outputs(beats_seen + BEATS, 0);
      join
      report_test(1, "single frame", err_start);

      // gaps on input, stalls on output
      err_start = errors;
      start_frame(1);
      fork
         send_words(1, FRAME_WORDS, 30);
         run_outputs(beats_seen + BEATS, 30);
      join
      report_test(2, "random gaps and stalls", err_start);

      // flags counted over the two frames above
      err_start = errors;
      check_value("window_last count", 2 * WINDOWS, wl_count);
      check_value("frame_last count", 2, fl_count);
      report_test(3, "last flags", err_start);

      // buffer wrap and frame restart
      err_start = errors;
      start_frame(2);
      fork
         begin
            send_words(2, FRAME_WORDS, 0);
            send_words(3, FRAME_WORDS, 0);
         end
         run_outputs(beats_seen + 2 * BEATS, 0);
      join
      report_test(4, "back to back frames", err_start);

      // output held off, input limited to the buffer size
      err_start = errors;
      start_frame(4);
      m_ready_i = 1'b0;
      acc_start = in_accepted;
      fork
         send_words(4, FRAME_WORDS, 0);
         begin
            repeat (200) begin
               @(posedge clk);
               #2;
               if (in_accepted - acc_start >= swu_pkg::BUF_WORDS) begin
                  check_value("s_ready_o", 1'b0, s_ready_o);
               end
            end
            if (in_accepted - acc_start > swu_pkg::BUF_WORDS) begin
               $display("error: %0d words accepted with output stalled, limit is %0d",
                        in_accepted - acc_start, swu_pkg::BUF_WORDS);
               errors++;
            end
            run_outputs(beats_seen + BEATS, 0);
         end
      join
      report_test(5, "input limit under stall", err_start);

      // reset with a frame half done
      err_start = errors;
      start_frame(5);
      fork
         send_words(5, 56, 0);
         run_outputs(beats_seen + 20, 0);
      join
      apply_reset();
      check_value("m_valid_o", 1'b0, m_valid_o);
      check_value("s_ready_o", 1'b1, s_ready_o);
      start_frame(6);
      m_ready_i = 1'b1;
      fork
         send_words(6, FRAME_WORDS, 0);
         run_outputs(beats_seen + BEATS, 0);
      join
      report_test(6, "reset mid frame", err_start);

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== verilog/swu_top.sv ====
module swu_top (
   input  logic           clk,
   input  logic           resetn,
   input  swu_pkg::word_t s_data_i,
   input  logic           s_valid_i,
   output logic           s_ready_o,
   output swu_pkg::beat_t m_beat_o,
   output logic           m_valid_o,
   input  logic           m_ready_i
);

   logic                          wr_en;
   logic [swu_pkg::ADDR_W-1:0]    wr_addr;
   logic [swu_pkg::ROW_CNT_W-1:0] rows_written;
   logic [swu_pkg::ROW_CNT_W-1:0] rows_released;
   logic                          frame_done;
   logic                          step;
   logic                          credit;
   logic                          row_done;
   logic [swu_pkg::OROW_W-1:0]    out_row;
   logic [swu_pkg::ADDR_W-1:0]    rd_addr;
   swu_pkg::rd_req_t              rd_req;
   swu_pkg::word_t                rd_data;

   ////////////////////
   // write side
   swu_write_ctrl u_write_ctrl (
      .clk             (clk),
      .resetn          (resetn),
      .s_valid_i       (s_valid_i),
      .s_ready_o       (s_ready_o),
      .rows_released_i (rows_released),
      .frame_done_i    (frame_done),
      .wr_en_o         (wr_en),
      .wr_addr_o       (wr_addr),
      .rows_written_o  (rows_written)
   );

   swu_line_buffer u_line_buffer (
      .clk       (clk),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr),
      .wr_data_i (s_data_i),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data)
   );

   ////////////////////
   // read side
   swu_window_fsm u_window_fsm (
      .clk             (clk),
      .resetn          (resetn),
      .rows_written_i  (rows_written),
      .credit_i        (credit),
      .row_done_i      (row_done),
      .step_o          (step),
      .rows_released_o (rows_released),
      .frame_done_o    (frame_done),
      .out_row_o       (out_row)
   );

   swu_read_addr u_read_addr (
      .clk        (clk),
      .resetn     (resetn),
      .step_i     (step),
      .out_row_i  (out_row),
      .rd_addr_o  (rd_addr),
      .rd_req_o   (rd_req),
      .row_done_o (row_done)
   );

   swu_out_stage u_out_stage (
      .clk       (clk),
      .resetn    (resetn),
      .issue_i   (step),
      .rd_req_i  (rd_req),
      .rd_data_i (rd_data),
      .credit_o  (credit),
      .m_beat_o  (m_beat_o),
      .m_valid_o (m_valid_o),
      .m_ready_i (m_ready_i)
   );

endmodule

// ==== verilog/swu_out_stage.sv ====
module swu_out_stage (
   input  logic             clk,
   input  logic             resetn,
   input  logic             issue_i,
   input  swu_pkg::rd_req_t rd_req_i,
   input  swu_pkg::word_t   rd_data_i,
   output logic             credit_o,
   output swu_pkg::beat_t   m_beat_o,
   output logic             m_valid_o,
   input  logic             m_ready_i
);

   swu_pkg::rd_req_t pend_req;
   logic             pend_valid;
   swu_pkg::beat_t   queue [2];
   logic             rd_ptr;
   logic             wr_ptr;
   logic [1:0]       count;
   swu_pkg::beat_t   in_beat;
   logic             pop;
   logic             push;
   logic             deq;

   ////////////////////
   // request delayed to line up with the RAM data
   always_ff @(posedge clk) begin
      if (!resetn) begin
         pend_valid <= 1'b0;
      end else begin
         pend_valid <= issue_i;
      end
   end

   always_ff @(posedge clk) begin
      if (issue_i) begin
         pend_req <= rd_req_i;
      end
   end

   assign in_beat = '{data: rd_data_i,
                      window_last: pend_req.window_last,
                      frame_last: pend_req.frame_last};

   // an empty queue passes the arriving beat straight through
   assign m_valid_o = (count != 2'd0) || pend_valid;
   assign m_beat_o  = (count != 2'd0) ? queue[rd_ptr] : in_beat;

   assign pop  = m_valid_o && m_ready_i;
   assign deq  = pop && (count != 2'd0);
   assign push = pend_valid && !(pop && count == 2'd0);

   // queued beats plus the read in flight stay within two
   assign credit_o = (count + {1'b0, pend_valid}) < 2'd2;

   ////////////////////
   // two entry queue
   always_ff @(posedge clk) begin
      if (push) begin
         queue[wr_ptr] <= in_beat;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         rd_ptr <= 1'b0;
         wr_ptr <= 1'b0;
         count  <= 2'd0;
      end else begin
         if (push) begin
            wr_ptr <= ~wr_ptr;
         end
         if (deq) begin
            rd_ptr <= ~rd_ptr;
         end
         case ({push, deq})
            2'b10:   count <= count + 2'd1;
            2'b01:   count <= count - 2'd1;
            default: count <= count;
         endcase
      end
   end

   no_overflow : assert property (
      @(posedge clk) disable iff (!resetn)
      push && !deq |-> count < 2'd2
   );

   // stalled beat holds until taken
   beat_held : assert property (
      @(posedge clk) disable iff (!resetn)
      m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_beat_o)
   );

endmodule

// ==== verilog/swu_read_addr.sv ====
module swu_read_addr (
   input  logic                       clk,
   input  logic                       resetn,
   input  logic                       step_i,
   input  logic [swu_pkg::OROW_W-1:0] out_row_i,
   output logic [swu_pkg::ADDR_W-1:0] rd_addr_o,
   output swu_pkg::rd_req_t           rd_req_o,
   output logic                       row_done_o
);

   logic [swu_pkg::CH_W-1:0]   ch;
   logic [swu_pkg::KER_W-1:0]  kw;
   logic [swu_pkg::KER_W-1:0]  kh;
   logic [swu_pkg::COL_W-1:0]  col;
   logic [swu_pkg::SLOT_W-1:0] base_slot;
   logic [swu_pkg::SLOT_W:0]   slot_sum;
   logic [swu_pkg::SLOT_W-1:0] row_slot;
   logic [swu_pkg::SLOT_W:0]   base_sum;
   logic [swu_pkg::SLOT_W-1:0] base_next;
   logic                       ch_last;
   logic                       kw_last;
   logic                       kh_last;
   logic                       col_last;
   logic                       win_last;
   logic                       frame_last;

   assign ch_last  = ch == swu_pkg::CH_W'(swu_pkg::EFF_CHANNELS - 1);
   assign kw_last  = kw == swu_pkg::KER_W'(swu_pkg::KERNEL - 1);
   assign kh_last  = kh == swu_pkg::KER_W'(swu_pkg::KERNEL - 1);
   assign col_last = col == swu_pkg::COL_W'(swu_pkg::OFM_WIDTH - 1);

   assign win_last   = ch_last && kw_last && kh_last;
   assign frame_last = win_last && col_last &&
                       (out_row_i == swu_pkg::OROW_W'(swu_pkg::OFM_HEIGHT - 1));
   assign row_done_o = step_i && win_last && col_last;

   ////////////////////
   // address generation
   always_comb begin
      // slot of input row out_row*STRIDE + kh, modulo BUF_ROWS
      slot_sum = {1'b0, base_slot} + (swu_pkg::SLOT_W + 1)'(kh);
      if (slot_sum >= swu_pkg::BUF_ROWS) begin
         row_slot = swu_pkg::SLOT_W'(slot_sum - swu_pkg::BUF_ROWS);
      end else begin
         row_slot = swu_pkg::SLOT_W'(slot_sum);
      end
      rd_addr_o = swu_pkg::ADDR_W'(row_slot * swu_pkg::ROW_WORDS +
                  (col * swu_pkg::STRIDE + kw) * swu_pkg::EFF_CHANNELS + ch);
   end

   // base slot of the next output row
   always_comb begin
      base_sum = {1'b0, base_slot} + (swu_pkg::SLOT_W + 1)'(swu_pkg::STRIDE);
      if (frame_last) begin
         base_next = '0;
      end else if (base_sum >= swu_pkg::BUF_ROWS) begin
         base_next = swu_pkg::SLOT_W'(base_sum - swu_pkg::BUF_ROWS);
      end else begin
         base_next = swu_pkg::SLOT_W'(base_sum);
      end
   end

   assign rd_req_o = '{addr: rd_addr_o, window_last: win_last, frame_last: frame_last};

   ////////////////////
   // channel, kernel column, kernel row, output column
   always_ff @(posedge clk) begin
      if (!resetn) begin
         ch        <= '0;
         kw        <= '0;
         kh        <= '0;
         col       <= '0;
         base_slot <= '0;
      end else if (step_i) begin
         ch <= ch_last ? '0 : ch + 1'b1;
         if (ch_last) begin
            kw <= kw_last ? '0 : kw + 1'b1;
            if (kw_last) begin
               kh <= kh_last ? '0 : kh + 1'b1;
               if (kh_last) begin
                  col <= col_last ? '0 : col + 1'b1;
               end
            end
         end
         if (row_done_o) begin
            base_slot <= base_next;
         end
      end
   end

endmodule

// ==== verilog/swu_window_fsm.sv ====
module swu_window_fsm (
   input  logic                          clk,
   input  logic                          resetn,
   input  logic [swu_pkg::ROW_CNT_W-1:0] rows_written_i,
   input  logic                          credit_i,
   input  logic                          row_done_i,
   output logic                          step_o,
   output logic [swu_pkg::ROW_CNT_W-1:0] rows_released_o,
   output logic                          frame_done_o,
   output logic [swu_pkg::OROW_W-1:0]    out_row_o
);

   typedef enum logic [1:0] {
      WAIT_ROWS,
      EMIT,
      RELEASE,
      FRAME_END
   } state_t;

   state_t                        state;
   state_t                        state_nxt;
   logic [swu_pkg::OROW_W-1:0]    out_row;
   logic [swu_pkg::ROW_CNT_W-1:0] rows_released;
   logic                          rows_ready;
   logic                          last_row;
   logic                          frame_written;

   // output row r needs input rows up to r*STRIDE + KERNEL - 1
   assign rows_ready = int'(rows_written_i) >=
                       int'(out_row) * swu_pkg::STRIDE + swu_pkg::KERNEL;

   assign last_row      = out_row == swu_pkg::OROW_W'(swu_pkg::OFM_HEIGHT - 1);
   assign frame_written = int'(rows_written_i) == swu_pkg::IFM_HEIGHT;

   assign step_o       = (state == EMIT) && credit_i;
   assign frame_done_o = (state == FRAME_END) && frame_written;

   ////////////////////
   // next state
   always_comb begin
      state_nxt = state;
      case (state)
         WAIT_ROWS: begin
            if (rows_ready) begin
               state_nxt = EMIT;
            end
         end
         EMIT: begin
            if (row_done_i) begin
               state_nxt = RELEASE;
            end
         end
         RELEASE: begin
            state_nxt = last_row ? FRAME_END : WAIT_ROWS;
         end
         FRAME_END: begin
            // trailing rows no window uses still have to arrive
            if (frame_written) begin
               state_nxt = WAIT_ROWS;
            end
         end
         default: begin
            state_nxt = WAIT_ROWS;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state <= WAIT_ROWS;
      end else begin
         state <= state_nxt;
      end
   end

   ////////////////////
   // output row and released rows
   always_ff @(posedge clk) begin
      if (!resetn || frame_done_o) begin
         out_row       <= '0;
         rows_released <= '0;
      end else if (state == RELEASE) begin
         rows_released <= rows_released + swu_pkg::ROW_CNT_W'(swu_pkg::STRIDE);
         if (!last_row) begin
            out_row <= out_row + 1'b1;
         end
      end
   end

   assign out_row_o       = out_row;
   assign rows_released_o = rows_released;

   // a row is only given back once the writer has filled it
   released_behind_written : assert property (
      @(posedge clk) disable iff (!resetn)
      rows_released_o <= rows_written_i
   );

endmodule

// ==== verilog/swu_write_ctrl.sv ====
module swu_write_ctrl (
   input  logic                          clk,
   input  logic                          resetn,
   input  logic                          s_valid_i,
   output logic                          s_ready_o,
   input  logic [swu_pkg::ROW_CNT_W-1:0] rows_released_i,
   input  logic                          frame_done_i,
   output logic                          wr_en_o,
   output logic [swu_pkg::ADDR_W-1:0]    wr_addr_o,
   output logic [swu_pkg::ROW_CNT_W-1:0] rows_written_o
);

   logic [swu_pkg::WCOL_W-1:0]    wr_col;
   logic [swu_pkg::ROW_CNT_W-1:0] wr_row;
   logic [swu_pkg::ADDR_W-1:0]    wr_addr;
   logic                          row_end;
   logic                          buf_end;
   logic                          row_fits;
   logic                          frame_open;

   // row being written must not reach a slot still needed by the reader
   assign row_fits   = int'(wr_row) < int'(rows_released_i) + swu_pkg::BUF_ROWS;
   assign frame_open = int'(wr_row) < swu_pkg::IFM_HEIGHT;
   assign s_ready_o  = row_fits && frame_open;
   assign wr_en_o    = s_valid_i && s_ready_o;

   assign row_end = wr_col == swu_pkg::WCOL_W'(swu_pkg::ROW_WORDS - 1);
   assign buf_end = wr_addr == swu_pkg::ADDR_W'(swu_pkg::BUF_WORDS - 1);

   ////////////////////
   // word, row and address counters
   always_ff @(posedge clk) begin
      if (!resetn || frame_done_i) begin
         wr_col  <= '0;
         wr_row  <= '0;
         wr_addr <= '0;
      end else if (wr_en_o) begin
         wr_addr <= buf_end ? '0 : wr_addr + 1'b1;
         if (row_end) begin
            wr_col <= '0;
            // counts complete rows
            wr_row <= wr_row + 1'b1;
         end else begin
            wr_col <= wr_col + 1'b1;
         end
      end
   end

   assign wr_addr_o      = wr_addr;
   assign rows_written_o = wr_row;

   // each write lands in the slot of the row being counted
   write_in_row_slot : assert property (
      @(posedge clk) disable iff (!resetn)
      wr_en_o |-> int'(wr_addr) / swu_pkg::ROW_WORDS == int'(wr_row) % swu_pkg::BUF_ROWS
   );

endmodule

// ==== verilog/swu_line_buffer.sv ====
module swu_line_buffer (
   input  logic                       clk,
   input  logic                       wr_en_i,
   input  logic [swu_pkg::ADDR_W-1:0] wr_addr_i,
   input  swu_pkg::word_t             wr_data_i,
   input  logic [swu_pkg::ADDR_W-1:0] rd_addr_i,
   output swu_pkg::word_t             rd_data_o
);

   // BUF_ROWS row slots laid out back to back
   swu_pkg::word_t mem [swu_pkg::BUF_WORDS];

   ////////////////////
   // write port
   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   ////////////////////
   // read port, one cycle latency
   always_ff @(posedge clk) begin
      rd_data_o <= mem[rd_addr_i];
   end

   // both controllers keep their addresses inside the buffer
   wr_addr_in_range : assert property (
      @(posedge clk) wr_en_i |-> wr_addr_i < swu_pkg::BUF_WORDS
   );

   rd_addr_in_range : assert property (
      @(posedge clk) !$isunknown(rd_addr_i) |-> rd_addr_i < swu_pkg::BUF_WORDS
   );

endmodule

// ==== verilog/swu_pkg.sv ====
package swu_pkg;

   // counter width helper, never narrower than one bit
   function automatic int cnt_w(int n);
      return (n > 1) ? $clog2(n) : 1;
   endfunction

   ////////////////////
   // input geometry
   localparam int IFM_WIDTH    = 8;
   localparam int IFM_HEIGHT   = 6;
   localparam int SIMD         = 2;
   localparam int PRECISION    = 8;
   localparam int CHANNELS     = 4;
   localparam int EFF_CHANNELS = CHANNELS / SIMD;

   ////////////////////
   // kernel and output geometry
   localparam int KERNEL     = 3;
   localparam int STRIDE     = 1;
   localparam int OFM_WIDTH  = (IFM_WIDTH - KERNEL) / STRIDE + 1;
   localparam int OFM_HEIGHT = (IFM_HEIGHT - KERNEL) / STRIDE + 1;

   // row buffer sizing
   localparam int ROW_WORDS = IFM_WIDTH * EFF_CHANNELS;
   localparam int BUF_ROWS  = KERNEL + STRIDE;
   localparam int BUF_WORDS = BUF_ROWS * ROW_WORDS;
   localparam int ADDR_W    = $clog2(BUF_WORDS);
   localparam int ROW_CNT_W = $clog2(IFM_HEIGHT + 1);

   // counter widths
   localparam int CH_W   = cnt_w(EFF_CHANNELS);
   localparam int KER_W  = cnt_w(KERNEL);
   localparam int COL_W  = cnt_w(OFM_WIDTH);
   localparam int OROW_W = cnt_w(OFM_HEIGHT);
   localparam int SLOT_W = cnt_w(BUF_ROWS);
   localparam int WCOL_W = cnt_w(ROW_WORDS);

   typedef logic [SIMD*PRECISION-1:0] word_t;

   typedef struct packed {
      word_t data;
      logic  window_last;
      logic  frame_last;
   } beat_t;

   // read request, travels alongside the RAM read
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic              window_last;
      logic              frame_last;
   } rd_req_t;

endpackage
